/* hdl/bus_slave_pkg.sv */
// bus slave package: widths, memory geometry and split timing of the serial target port
package bus_slave_pkg;

	// serial address bits shifted in per request
	localparam int ADDR_WIDTH = 12;

	// width of one data word on rx_data and tx_data
	localparam int DATA_WIDTH = 8;

	// only the low address bits reach the memory decoder
	// higher bits alias onto the same locations
	localparam int MEM_ADDR_WIDTH = 6;

	// number of bytes in the local memory
	localparam int MEM_DEPTH = 64;

	// cycles during which split_en frees the bus on a read
	localparam int SPLIT_CYCLES = 4;

	// down-counter width, holds SPLIT_CYCLES - 1
	localparam int TIMER_WIDTH = 3;

	// address payload as collected from rx_address
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// data payload, both for writes and for the read answer
	typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

/* hdl/serial_rx.sv */
// serial receiver: collects one lsb-first payload from a single bit line after a start pulse
module serial_rx
	import bus_slave_pkg::*;
#(
	parameter type payload_t = data_t
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  logic     bit_in,
	output payload_t payload,
	output logic     done
);

	// payload width and matching bit counter width
	localparam int W = $bits(payload_t);
	localparam int CW = $clog2(W);

	// receive in progress
	logic busy;
	// bits taken so far
	logic [CW-1:0] bit_cnt;
	// shift register, holds the word once complete
	payload_t shift_q;

	// control path
	// start only arms the receiver, first bit comes one edge later
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			bit_cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			// done is a single-cycle pulse
			done <= 1'b0;
			if (start)
			begin
				busy <= 1'b1;
				bit_cnt <= '0;
			end
			else if (busy)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				// last bit sampled here
				if (bit_cnt == CW'(W - 1))
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// data path
	// new bits enter at the top and move down, so bit 0 ends up at the bottom
	always_ff @(posedge clk)
	begin
		if (busy && !start)
		begin
			shift_q <= {bit_in, shift_q[W-1:1]};
		end
	end

	// held until the next start
	assign payload = shift_q;

endmodule

/* hdl/serial_tx.sv */
// serial transmitter: shifts the read byte out lsb first, advancing only while master_ready is high
module serial_tx
	import bus_slave_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  load,
	input  data_t word,
	input  logic  master_ready,
	output logic  tx_data,
	output logic  tx_done
);

	// counter sized for DATA_WIDTH bits
	localparam int CW = $clog2(DATA_WIDTH);

	// a word is being sent
	logic busy;
	// bits accepted by the master so far
	logic [CW-1:0] bit_cnt;
	// outgoing word, current bit sits at position 0
	data_t shift_q;

	// an edge where the master takes the current bit
	logic advance;
	assign advance = busy && master_ready;

	// control path
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			bit_cnt <= '0;
		end
		else if (load)
		begin
			busy <= 1'b1;
			bit_cnt <= '0;
		end
		else if (advance)
		begin
			bit_cnt <= bit_cnt + 1'b1;
			// last bit taken, stop
			if (bit_cnt == CW'(DATA_WIDTH - 1))
			begin
				busy <= 1'b0;
			end
		end
	end

	// data path
	// load presents bit 0 at once
	// master_ready low just holds the current bit
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			shift_q <= word;
		end
		else if (advance)
		begin
			shift_q <= shift_q >> 1;
		end
	end

	assign tx_data = shift_q[0];

	// pulse comes with the last accepted bit
	assign tx_done = advance && (bit_cnt == CW'(DATA_WIDTH - 1));

endmodule

/* hdl/split_timer.sv */
// split timer: counts down the cycles during which a read releases the bus
module split_timer
	import bus_slave_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic load,
	output logic expired
);

	// remaining split cycles after the current one
	logic [TIMER_WIDTH-1:0] count;
	// a split is being timed
	logic running;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			running <= 1'b0;
			count <= '0;
		end
		else if (load)
		begin
			// load cycle itself is the first split cycle
			running <= 1'b1;
			count <= TIMER_WIDTH'(SPLIT_CYCLES - 1);
		end
		else if (running)
		begin
			if (count == '0)
				running <= 1'b0;
			else
				count <= count - 1'b1;
		end
	end

	// high for the single cycle where the count sits at zero
	assign expired = running && (count == '0);

endmodule

/* hdl/slave_ctrl.sv */
// slave controller: transaction FSM that sequences receive, memory access, split and read answer
module slave_ctrl
(
	input  logic clk,
	input  logic rst,
	input  logic read_en,
	input  logic write_en,
	input  logic master_valid,
	input  logic addr_done,
	input  logic expired,
	input  logic tx_done,
	output logic rx_start,
	output logic mem_we,
	output logic mem_re,
	output logic timer_load,
	output logic tx_load,
	output logic slave_ready,
	output logic split_en,
	output logic slave_valid
);

	// IDLE waits for a request
	// RECEIVE shifts address and data in
	// SPLIT keeps the bus free while the memory answers
	// VALID sends the byte back
	typedef enum logic [1:0]
	{
		IDLE,
		RECEIVE,
		SPLIT,
		VALID
	} state_t;

	state_t state;

	// kind of request, kept for the whole receive phase
	logic is_write;

	// a strobe together with master_valid
	logic request;
	assign request = master_valid && (read_en || write_en);

	// serial payload fully in
	logic rx_end;
	assign rx_end = (state == RECEIVE) && addr_done;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			is_write <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (request)
					begin
						// write wins when both strobes are up
						is_write <= write_en;
						state <= RECEIVE;
					end
				end
				RECEIVE:
				begin
					// writes finish here, reads go on to the split
					if (addr_done)
						state <= is_write ? IDLE : SPLIT;
				end
				SPLIT:
				begin
					if (expired)
						state <= VALID;
				end
				VALID:
				begin
					// last bit taken by the master
					if (tx_done)
						state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// both receivers armed on the accepting edge
	assign rx_start = (state == IDLE) && request;

	// memory strobes at the end of the address
	assign mem_we = rx_end && is_write;
	assign mem_re = rx_end && !is_write;

	// split timing starts with the memory read
	assign timer_load = rx_end && !is_write;

	// transmitter picks up the read byte as the split ends
	assign tx_load = (state == SPLIT) && expired;

	// bus levels straight from the state
	assign slave_ready = (state == IDLE);
	assign split_en = (state == SPLIT);
	assign slave_valid = (state == VALID);

endmodule

/* hdl/slave_mem.sv */
// slave memory: 64-byte store with synchronous write and registered read, low address bits only
module slave_mem
	import bus_slave_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  we,
	input  logic  re,
	input  addr_t addr,
	input  data_t wr_data,
	output data_t rd_data
);

	// storage, contents undefined until written
	data_t mem [MEM_DEPTH];

	// upper address bits ignored, so addresses alias every MEM_DEPTH bytes
	logic [MEM_ADDR_WIDTH-1:0] index;
	assign index = addr[MEM_ADDR_WIDTH-1:0];

	// write port
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[index] <= wr_data;
		end
	end

	// read port
	// data valid one cycle after re and held until the next read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_data <= '0;
		end
		else if (re)
		begin
			rd_data <= mem[index];
		end
	end

endmodule

/* hdl/bus_slave.sv */
// bus slave: serial target port joining controller, receivers, memory, split timer and transmitter
module bus_slave
	import bus_slave_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic read_en,
	input  logic write_en,
	input  logic master_valid,
	input  logic master_ready,
	input  logic rx_address,
	input  logic rx_data,
	output logic slave_ready,
	output logic split_en,
	output logic slave_valid,
	output logic tx_data
);

	// controller strobes
	logic rx_start;
	logic mem_we;
	logic mem_re;
	logic timer_load;
	logic tx_load;

	// status back to the controller
	logic addr_done;
	logic expired;
	logic tx_done;

	// payloads and read byte
	addr_t addr_payload;
	data_t data_payload;
	data_t rd_data;

	slave_ctrl slave_ctrl_inst
	(
		.clk          (clk),
		.rst          (rst),
		.read_en      (read_en),
		.write_en     (write_en),
		.master_valid (master_valid),
		.addr_done    (addr_done),
		.expired      (expired),
		.tx_done      (tx_done),
		.rx_start     (rx_start),
		.mem_we       (mem_we),
		.mem_re       (mem_re),
		.timer_load   (timer_load),
		.tx_load      (tx_load),
		.slave_ready  (slave_ready),
		.split_en     (split_en),
		.slave_valid  (slave_valid)
	);

	split_timer split_timer_inst
	(
		.clk     (clk),
		.rst     (rst),
		.load    (timer_load),
		.expired (expired)
	);

	// address receiver, its done ends the receive phase
	serial_rx #(.payload_t(addr_t)) addr_rx_inst
	(
		.clk     (clk),
		.rst     (rst),
		.start   (rx_start),
		.bit_in  (rx_address),
		.payload (addr_payload),
		.done    (addr_done)
	);

	// data receiver, shorter so it is always done before the address
	serial_rx #(.payload_t(data_t)) data_rx_inst
	(
		.clk     (clk),
		.rst     (rst),
		.start   (rx_start),
		.bit_in  (rx_data),
		.payload (data_payload),
		.done    ()
	);

	slave_mem slave_mem_inst
	(
		.clk     (clk),
		.rst     (rst),
		.we      (mem_we),
		.re      (mem_re),
		.addr    (addr_payload),
		.wr_data (data_payload),
		.rd_data (rd_data)
	);

	serial_tx serial_tx_inst
	(
		.clk          (clk),
		.rst          (rst),
		.load         (tx_load),
		.word         (rd_data),
		.master_ready (master_ready),
		.tx_data      (tx_data),
		.tx_done      (tx_done)
	);

endmodule

/* test/bus_slave_tb.sv */
// bus slave testbench: serial writes and reads against a reference memory, with bus timing checks
module bus_slave_tb
	import bus_slave_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int NUM_TESTS = 40;
	// one write and one read, every tx bit allowed up to 8 cycles of stall
	localparam int TXN_CYCLES = 2 * (ADDR_WIDTH + 3) + SPLIT_CYCLES + 8 * DATA_WIDTH;
	localparam int WATCHDOG_NS = 2 * (NUM_TESTS * TXN_CYCLES + 20) * CLK_PERIOD;

	logic clk = 1'b0;
	logic rst;
	logic read_en;
	logic write_en;
	logic master_valid;
	logic master_ready;
	logic rx_address;
	logic rx_data;
	logic slave_ready;
	logic split_en;
	logic slave_valid;
	logic tx_data;

	// mirror of the slave memory, indexed by the low address bits
	data_t ref_mem [MEM_DEPTH];
	// locations written so far
	logic [MEM_ADDR_WIDTH-1:0] written [$];
	int unsigned lcg_state = 34697;
	logic seen_request = 1'b0;
	// length of the current split phase
	int split_run = 0;

	// request taken by the port at the coming edge
	logic accept;
	logic accept_write;
	logic accept_read;
	assign accept = slave_ready && master_valid && (read_en || write_en);
	assign accept_write = accept && write_en;
	assign accept_read = accept && !write_en;

	bus_slave bus_slave_inst
	(
		.clk          (clk),
		.rst          (rst),
		.read_en      (read_en),
		.write_en     (write_en),
		.master_valid (master_valid),
		.master_ready (master_ready),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.slave_ready  (slave_ready),
		.split_en     (split_en),
		.slave_valid  (slave_valid),
		.tx_data      (tx_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h",
			$time, name, expected, actual);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic abort_run(input string reason);
		$display("error at %0t: %s", $time, reason);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	// next drive point, just after the rising edge
	task automatic advance_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// one strobe cycle, then address and data lsb first
	task automatic send_request(input logic is_write, input addr_t addr, input data_t data);
		addr_t a_bits;
		data_t d_bits;
		a_bits = addr;
		d_bits = data;
		while (!slave_ready)
			advance_cycle();
		seen_request = 1'b1;
		master_valid = 1'b1;
		write_en = is_write;
		read_en = !is_write;
		advance_cycle();
		master_valid = 1'b0;
		write_en = 1'b0;
		read_en = 1'b0;
		// data runs out after 8 bits and then sends zeros
		repeat (ADDR_WIDTH)
		begin
			rx_address = a_bits[0];
			rx_data = d_bits[0];
			a_bits = a_bits >> 1;
			d_bits = d_bits >> 1;
			advance_cycle();
		end
		rx_address = 1'b0;
		rx_data = 1'b0;
	endtask

	task automatic write_word(input addr_t addr, input data_t data);
		send_request(1'b1, addr, data);
		ref_mem[addr[MEM_ADDR_WIDTH-1:0]] = data;
	endtask

	// collects tx_data on every cycle the master takes a bit
	task automatic read_word(input addr_t addr);
		data_t got;
		int nbits;
		logic seen_valid;
		logic finished;
		got = '0;
		nbits = 0;
		seen_valid = 1'b0;
		finished = 1'b0;
		send_request(1'b0, addr, '0);
		while (!finished)
		begin
			// about one cycle in four without master_ready
			master_ready = ((next_rand() >> 16) % 32'd4) != 32'd0;
			@(negedge clk);
			if (slave_valid)
			begin
				seen_valid = 1'b1;
				if (master_ready && nbits < DATA_WIDTH)
					got = {tx_data, got[DATA_WIDTH-1:1]};
				if (master_ready)
					nbits++;
			end
			else if (seen_valid)
				finished = 1'b1;
			advance_cycle();
		end
		master_ready = 1'b0;
		assert (nbits == DATA_WIDTH)
			else report_mismatch("tx bits accepted", 32'(DATA_WIDTH), 32'(nbits));
		assert (got == ref_mem[addr[MEM_ADDR_WIDTH-1:0]])
			else report_mismatch("tx_data", 32'(ref_mem[addr[MEM_ADDR_WIDTH-1:0]]), 32'(got));
	endtask

	// idle levels up to the first request, split length on every read
	always @(negedge clk)
	begin
		if (!rst && !seen_request)
		begin
			assert (slave_ready) else report_mismatch("slave_ready", 32'd1, 32'(slave_ready));
			assert (!split_en) else report_mismatch("split_en", 32'd0, 32'(split_en));
			assert (!slave_valid) else report_mismatch("slave_valid", 32'd0, 32'(slave_valid));
		end
		if (split_en)
			split_run = split_run + 1;
		else if (split_run != 0)
		begin
			assert (split_run == SPLIT_CYCLES)
				else report_mismatch("split_en cycles", 32'(SPLIT_CYCLES), 32'(split_run));
			split_run = 0;
		end
	end

	// busy from the edge after acceptance
	assert property (@(posedge clk) disable iff (rst) accept |=> !slave_ready)
		else report_mismatch("slave_ready", 32'd0, 32'd1);
	// ready returns only when a write completes or a read answer ends
	assert property (@(posedge clk) disable iff (rst)
		$rose(slave_ready) |-> ($past(accept_write, 14) || $fell(slave_valid)))
		else abort_run("slave_ready rose before the transaction ended");
	// write done 13 cycles after the accepting edge
	assert property (@(posedge clk) disable iff (rst) $past(accept_write, 13) |-> !slave_ready)
		else report_mismatch("slave_ready", 32'd0, 32'd1);
	assert property (@(posedge clk) disable iff (rst) $past(accept_write, 14) |-> slave_ready)
		else report_mismatch("slave_ready", 32'd1, 32'd0);
	// split starts on the edge that ends the address
	assert property (@(posedge clk) disable iff (rst) $past(accept_read, 13) |-> !split_en)
		else report_mismatch("split_en", 32'd0, 32'd1);
	assert property (@(posedge clk) disable iff (rst) $past(accept_read, 14) |-> split_en)
		else report_mismatch("split_en", 32'd1, 32'd0);
	assert property (@(posedge clk) disable iff (rst) (split_en || slave_valid) |-> !slave_ready)
		else report_mismatch("slave_ready", 32'd0, 32'd1);
	assert property (@(posedge clk) disable iff (rst) !(split_en && slave_valid))
		else abort_run("split_en and slave_valid high in the same cycle");
	// handover from split to valid in one cycle
	assert property (@(posedge clk) disable iff (rst) $rose(slave_valid) |-> $fell(split_en))
		else abort_run("slave_valid rose without split_en falling");
	assert property (@(posedge clk) disable iff (rst) $fell(split_en) |-> $rose(slave_valid))
		else abort_run("split_en fell without slave_valid rising");
	// back-pressure freezes the answer
	assert property (@(posedge clk) disable iff (rst)
		(slave_valid && !master_ready) |=> (slave_valid && $stable(tx_data)))
		else abort_run("tx_data or slave_valid changed while master_ready was low");

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("watchdog timeout, the tests did not finish in time");
	end

	initial
	begin
		addr_t wr_addr;
		addr_t rd_addr;
		data_t wr_data;
		logic [MEM_ADDR_WIDTH-1:0] pick;
		int idx;
		int t;
		rst = 1'b1;
		read_en = 1'b0;
		write_en = 1'b0;
		master_valid = 1'b0;
		master_ready = 1'b0;
		rx_address = 1'b0;
		rx_data = 1'b0;
		repeat (5) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		// idle stretch before the first request
		repeat (3) advance_cycle();
		for (t = 0; t < NUM_TESTS; t++)
		begin
			wr_addr = addr_t'(next_rand() >> 8);
			wr_data = data_t'(next_rand() >> 8);
			write_word(wr_addr, wr_data);
			written.push_back(wr_addr[MEM_ADDR_WIDTH-1:0]);
			// read back any written location through a random alias
			idx = int'((next_rand() >> 8) % 32'(written.size()));
			pick = written[idx];
			rd_addr = addr_t'(next_rand() >> 8);
			rd_addr[MEM_ADDR_WIDTH-1:0] = pick;
			read_word(rd_addr);
		end
		repeat (3) advance_cycle();
		$display("sim passed");
		$finish;
	end

endmodule

/* verilog.f */
hdl/bus_slave_pkg.sv
hdl/serial_rx.sv
hdl/serial_tx.sv
hdl/split_timer.sv
hdl/slave_ctrl.sv
hdl/slave_mem.sv
hdl/bus_slave.sv
test/bus_slave_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the bus slave testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module bus_slave_tb -f verilog.f
if [ $? -ne 0 ]; then
	echo "build error"
	exit 1
fi

output=$(./obj_dir/Vbus_slave_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
